/* files.f */
common/afifo_pkg.sv
common/afifo_mem_if.sv
source/afifo_gray_pointer.sv
source/afifo_ptr_sync.sv
afifo_ctrl/afifo_write_ctrl.sv
afifo_ctrl/afifo_read_ctrl.sv
source/afifo_width_conv.sv
source/afifo_dpram.sv
source/afifo_top.sv
dv/afifo_properties.sv
dv/afifo_tb.sv

/* Bender.yml */
package:
  name: afifo

sources:
  - files:
      - common/afifo_pkg.sv
      - common/afifo_mem_if.sv
      - source/afifo_gray_pointer.sv
      - source/afifo_ptr_sync.sv
      - afifo_ctrl/afifo_write_ctrl.sv
      - afifo_ctrl/afifo_read_ctrl.sv
      - source/afifo_width_conv.sv
      - source/afifo_dpram.sv
      - source/afifo_top.sv
  - target: test
    files:
      - dv/afifo_properties.sv
      - dv/afifo_tb.sv

/* dv/afifo_tb.sv */
`timescale 1ns/1ps

module afifo_tb;
   import afifo_pkg::*;

   typedef enum int {OP_IDLE, OP_WRITE, OP_READ, OP_STREAM} op_e;

   localparam int NUM_ROWS = 5;

   // operation, strobe count, final level, flags as {w_full, w_empty, r_full, r_empty}
   // a level of -1 leaves the end state to the model and the flag rules
   op_e        row_op    [NUM_ROWS] = '{OP_IDLE, OP_WRITE, OP_READ, OP_STREAM, OP_READ};
   int         row_cnt   [NUM_ROWS] = '{0, 9, 17, 40, 24};
   int         row_level [NUM_ROWS] = '{0, 16, 0, -1, 0};
   logic [3:0] row_flags [NUM_ROWS] = '{4'b0101, 4'b1010, 4'b0101, 4'b0000, 4'b0101};

   logic                w_clk_i;
   logic                r_clk_i;
   logic                rst_i;
   logic                w_en_i;
   logic [W_DATA_W-1:0] w_data_i;
   logic                w_full_o;
   logic                w_empty_o;
   logic [ADDR_W:0]     w_level_o;
   logic                r_en_i;
   logic [R_DATA_W-1:0] r_data_o;
   logic                r_full_o;
   logic                r_empty_o;
   logic [ADDR_W:0]     r_level_o;

   // reference model, one entry per byte in read order
   logic [R_DATA_W-1:0] model_q [$];
   logic [R_DATA_W-1:0] last_byte;
   bit                  have_byte = 1'b0;

   integer seed = 32'hf463_bcc0;
   integer rd_seed;
   int     err_cnt = 0;
   int     check_cnt = 0;
   int     row_err;

   afifo_top i_afifo_top (
      .w_clk_i  (w_clk_i),
      .r_clk_i  (r_clk_i),
      .rst_i    (rst_i),
      .w_en_i   (w_en_i),
      .w_data_i (w_data_i),
      .w_full_o (w_full_o),
      .w_empty_o(w_empty_o),
      .w_level_o(w_level_o),
      .r_en_i   (r_en_i),
      .r_data_o (r_data_o),
      .r_full_o (r_full_o),
      .r_empty_o(r_empty_o),
      .r_level_o(r_level_o)
   );

   initial begin
      w_clk_i = 1'b0;
      forever #5 w_clk_i = ~w_clk_i;
   end

   initial begin
      r_clk_i = 1'b0;
      forever #7 r_clk_i = ~r_clk_i;
   end

   task automatic compare(input string name, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
      check_cnt++;
      if (act_v !== exp_v) begin
         err_cnt++;
         $display("MISMATCH time %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
      end
   endtask

   task automatic write_burst(input int n, input bit random_en);
      int sent;
      bit en;
      sent = 0;
      @(posedge w_clk_i);
      #1;
      while (sent < n) begin
         en = random_en ? (($random(seed) & 3) != 0) : 1'b1;
         w_en_i   = en;
         w_data_i = $random(seed);
         // full only moves on w_clk_i edges, so this value decides the next edge
         if (en && !w_full_o) begin
            model_q.push_back(w_data_i[7:0]);
            model_q.push_back(w_data_i[15:8]);
         end
         if (en) begin
            sent++;
         end
         @(posedge w_clk_i);
         #1;
      end
      w_en_i = 1'b0;
   endtask

   task automatic read_burst(input int n, input bit random_en);
      int sent;
      bit en;
      sent = 0;
      @(posedge r_clk_i);
      #1;
      while (sent < n) begin
         en = random_en ? (($random(rd_seed) & 3) != 0) : 1'b1;
         r_en_i = en;
         if (en && !r_empty_o) begin
            if (model_q.size() == 0) begin
               err_cnt++;
               $display("ERROR time %0t: read accepted while the model holds no data", $time);
            end else begin
               last_byte = model_q.pop_front();
               have_byte = 1'b1;
            end
         end
         if (en) begin
            sent++;
         end
         @(posedge r_clk_i);
         #1;
         // a rejected read leaves the previous byte on the port
         if (have_byte) begin
            compare("r_data_o", last_byte, r_data_o);
         end
      end
      r_en_i = 1'b0;
   endtask

   task automatic settle_and_check(input int row);
      int         lvl;
      logic [3:0] exp_flags;
      repeat (4) @(posedge w_clk_i);
      repeat (4) @(posedge r_clk_i);
      #1;
      lvl = model_q.size();
      if (row_level[row] >= 0) begin
         compare("model level", row_level[row], lvl);
         exp_flags = row_flags[row];
      end else begin
         // write side wants a whole word of room or data, read side one byte
         exp_flags = {lvl > int'(FIFO_SIZE) - 2, lvl < 2, lvl > int'(FIFO_SIZE) - 1, lvl < 1};
      end
      compare("w_level_o", lvl, w_level_o);
      compare("r_level_o", lvl, r_level_o);
      compare("w_full_o", exp_flags[3], w_full_o);
      compare("w_empty_o", exp_flags[2], w_empty_o);
      compare("r_full_o", exp_flags[1], r_full_o);
      compare("r_empty_o", exp_flags[0], r_empty_o);
   endtask

   initial begin
      w_en_i   = 1'b0;
      r_en_i   = 1'b0;
      w_data_i = '0;
      rst_i    = 1'b1;
      rd_seed  = ~seed;
      repeat (3) @(posedge r_clk_i);
      #1;
      rst_i = 1'b0;
      for (int row = 0; row < NUM_ROWS; row++) begin
         row_err = err_cnt;
         case (row_op[row])
            OP_WRITE:  write_burst(row_cnt[row], 1'b0);
            OP_READ:   read_burst(row_cnt[row], 1'b0);
            OP_STREAM: begin
               fork
                  write_burst(row_cnt[row], 1'b1);
                  read_burst(row_cnt[row], 1'b1);
               join
            end
            default: ;
         endcase
         settle_and_check(row);
         $display("row %0d %s finished with %0d errors", row, row_op[row].name(),
                  err_cnt - row_err);
      end
      err_cnt += i_afifo_top.i_afifo_properties.fail_cnt;
      $display("checks %0d, errors %0d, assertion failures %0d", check_cnt, err_cnt,
               i_afifo_top.i_afifo_properties.fail_cnt);
      if (err_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // limit grows with the table, slow clock period with plenty of margin
   initial begin
      int total;
      total = 0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         total += row_cnt[i];
      end
      #(total * 14 * 4);
      $display("timeout: the run did not finish within %0d ns", total * 14 * 4);
      $display("Test FAILED");
      $finish;
   end

endmodule

/* dv/afifo_properties.sv */
`timescale 1ns/1ps

module afifo_properties (
   input logic                         w_clk_i,
   input logic                         r_clk_i,
   input logic                         rst_i,
   input logic                         w_full_o,
   input logic                         w_empty_o,
   input logic                         r_empty_o,
   input logic [afifo_pkg::W_ADDR_W:0] wr_gray_i,
   input logic [afifo_pkg::ADDR_W:0]   rd_gray_i
);

   int unsigned fail_cnt = 0;

   // write pointer holds while full
   wr_hold_when_full: assert property (@(posedge w_clk_i) disable iff (rst_i)
      w_full_o |=> $stable(wr_gray_i))
      else begin
         $error("write pointer advanced while full");
         fail_cnt++;
      end

   // read pointer holds while empty
   rd_hold_when_empty: assert property (@(posedge r_clk_i) disable iff (rst_i)
      r_empty_o |=> $stable(rd_gray_i))
      else begin
         $error("read pointer advanced while empty");
         fail_cnt++;
      end

   w_flags_exclusive: assert property (@(posedge w_clk_i) disable iff (rst_i)
      !(w_full_o && w_empty_o))
      else begin
         $error("write side full and empty together");
         fail_cnt++;
      end

   // both sides come out of reset empty
   empty_after_reset: assert property (@(posedge r_clk_i)
      $fell(rst_i) |-> (r_empty_o && w_empty_o))
      else begin
         $error("empty flags low after reset");
         fail_cnt++;
      end

endmodule

bind afifo_top afifo_properties i_afifo_properties (
   .w_clk_i  (w_clk_i),
   .r_clk_i  (r_clk_i),
   .rst_i    (rst_i),
   .w_full_o (w_full_o),
   .w_empty_o(w_empty_o),
   .r_empty_o(r_empty_o),
   .wr_gray_i(wr_gray_w),
   .rd_gray_i(rd_gray_r)
);

/* source/afifo_top.sv */
`timescale 1ns/1ps

module afifo_top (
   input  logic                              w_clk_i,
   input  logic                              r_clk_i,
   input  logic                              rst_i,
   input  logic                              w_en_i,
   input  logic [afifo_pkg::W_DATA_W-1:0]    w_data_i,
   output logic                              w_full_o,
   output logic                              w_empty_o,
   output logic [afifo_pkg::ADDR_W:0]        w_level_o,
   input  logic                              r_en_i,
   output logic [afifo_pkg::R_DATA_W-1:0]    r_data_o,
   output logic                              r_full_o,
   output logic                              r_empty_o,
   output logic [afifo_pkg::ADDR_W:0]        r_level_o
);
   import afifo_pkg::*;

   // gray pointers on each side of the crossing
   logic [W_ADDR_W:0] wr_gray_w;
   logic [W_ADDR_W:0] wr_gray_r;
   logic [ADDR_W:0]   rd_gray_r;
   logic [ADDR_W:0]   rd_gray_w;
   logic [ADDR_W:0]   rd_ptr;
   logic              rd_accept;

   afifo_mem_if i_mem_bus ();

   assign i_mem_bus.w_data = w_data_i;

   afifo_write_ctrl i_write_ctrl (
      .w_clk_i  (w_clk_i),
      .rst_i    (rst_i),
      .w_en_i   (w_en_i),
      .rd_gray_i(rd_gray_w),
      .wr_gray_o(wr_gray_w),
      .w_full_o (w_full_o),
      .w_empty_o(w_empty_o),
      .w_level_o(w_level_o),
      .mem      (i_mem_bus.wr_src)
   );

   // write pointer into r_clk_i
   afifo_ptr_sync #(
      .PTR_W(W_ADDR_W + 1)
   ) i_wr_ptr_sync (
      .clk_i (r_clk_i),
      .rst_i (rst_i),
      .gray_i(wr_gray_w),
      .gray_o(wr_gray_r)
   );

   // read pointer into w_clk_i
   afifo_ptr_sync #(
      .PTR_W(ADDR_W + 1)
   ) i_rd_ptr_sync (
      .clk_i (w_clk_i),
      .rst_i (rst_i),
      .gray_i(rd_gray_r),
      .gray_o(rd_gray_w)
   );

   afifo_read_ctrl i_read_ctrl (
      .r_clk_i    (r_clk_i),
      .rst_i      (rst_i),
      .r_en_i     (r_en_i),
      .wr_gray_i  (wr_gray_r),
      .rd_gray_o  (rd_gray_r),
      .rd_ptr_o   (rd_ptr),
      .rd_accept_o(rd_accept),
      .r_full_o   (r_full_o),
      .r_empty_o  (r_empty_o),
      .r_level_o  (r_level_o)
   );

   afifo_width_conv i_width_conv (
      .r_clk_i    (r_clk_i),
      .rst_i      (rst_i),
      .rd_accept_i(rd_accept),
      .rd_ptr_i   (rd_ptr),
      .mem        (i_mem_bus.rd_src),
      .r_data_o   (r_data_o)
   );

   afifo_dpram i_dpram (
      .w_clk_i(w_clk_i),
      .r_clk_i(r_clk_i),
      .mem    (i_mem_bus.ram)
   );

endmodule

/* source/afifo_dpram.sv */
`timescale 1ns/1ps

module afifo_dpram (
   input  logic      w_clk_i,
   input  logic      r_clk_i,
   afifo_mem_if.ram  mem
);
   import afifo_pkg::*;

   mem_word_u ram_q [1 << W_ADDR_W];

   // write port
   always_ff @(posedge w_clk_i) begin
      if (mem.w_en) begin
         ram_q[mem.w_addr].raw <= mem.w_data;
      end
   end

   // read port holds its last word between reads
   always_ff @(posedge r_clk_i) begin
      if (mem.r_en) begin
         mem.r_data <= ram_q[mem.r_addr].raw;
      end
   end

endmodule

/* source/afifo_width_conv.sv */
`timescale 1ns/1ps

module afifo_width_conv (
   input  logic                              r_clk_i,
   input  logic                              rst_i,
   input  logic                              rd_accept_i,
   input  logic [afifo_pkg::ADDR_W:0]        rd_ptr_i,
   afifo_mem_if.rd_src                       mem,
   output logic [afifo_pkg::R_DATA_W-1:0]    r_data_o
);
   import afifo_pkg::*;

   logic [RATIO_W-1:0] lane_q;
   mem_word_u          rd_word;

   // upper byte address bits pick the word, the top wrap bit is not an address
   assign mem.r_en   = rd_accept_i;
   assign mem.r_addr = rd_ptr_i[ADDR_W-1:RATIO_W];

   // lane index follows the RAM read by one cycle, same as its data
   always_ff @(posedge r_clk_i) begin
      if (rst_i) begin
         lane_q <= '0;
      end else if (rd_accept_i) begin
         lane_q <= rd_ptr_i[RATIO_W-1:0];
      end
   end

   // lane 0 holds the low byte, so words come out low byte first
   assign rd_word  = mem.r_data;
   assign r_data_o = rd_word.lanes[lane_q];

endmodule

/* afifo_ctrl/afifo_read_ctrl.sv */
`timescale 1ns/1ps

module afifo_read_ctrl (
   input  logic                          r_clk_i,
   input  logic                          rst_i,
   input  logic                          r_en_i,
   input  logic [afifo_pkg::W_ADDR_W:0]  wr_gray_i,
   output logic [afifo_pkg::ADDR_W:0]    rd_gray_o,
   output logic [afifo_pkg::ADDR_W:0]    rd_ptr_o,
   output logic                          rd_accept_o,
   output logic                          r_full_o,
   output logic                          r_empty_o,
   output logic [afifo_pkg::ADDR_W:0]    r_level_o
);
   import afifo_pkg::*;

   logic [1:0]      rst_sync_q;
   logic            rst_r;
   logic            rd_accept;
   logic [ADDR_W:0] rd_bin;
   logic [ADDR_W:0] wr_bin;
   logic [ADDR_W:0] wr_bin_n;
   logic [ADDR_W:0] r_level;

   // local copy of the reset, released two r_clk_i edges late
   always_ff @(posedge r_clk_i) begin
      if (rst_i) begin
         rst_sync_q <= 2'b11;
      end else begin
         rst_sync_q <= {rst_sync_q[0], 1'b0};
      end
   end

   assign rst_r = rst_sync_q[1];

   // reads while empty are dropped
   assign rd_accept = r_en_i & ~r_empty_o;

   afifo_gray_pointer #(
      .PTR_W(ADDR_W + 1)
   ) i_rd_ptr (
      .clk_i (r_clk_i),
      .rst_i (rst_r),
      .inc_i (rd_accept),
      .bin_o (rd_bin),
      .gray_o(rd_gray_o)
   );

   // synced write pointer counts words, one shift turns it into bytes
   assign wr_bin   = gray_to_bin({{RATIO_W{1'b0}}, wr_gray_i});
   assign wr_bin_n = wr_bin << RATIO_W;

   assign r_level   = wr_bin_n - rd_bin;
   assign r_level_o = r_level;

   assign r_full_o  = r_level > (FIFO_SIZE - (ADDR_W + 1)'(1));
   assign r_empty_o = r_level < (ADDR_W + 1)'(1);

   assign rd_ptr_o    = rd_bin;
   assign rd_accept_o = rd_accept;

endmodule

/* afifo_ctrl/afifo_write_ctrl.sv */
`timescale 1ns/1ps

module afifo_write_ctrl (
   input  logic                          w_clk_i,
   input  logic                          rst_i,
   input  logic                          w_en_i,
   input  logic [afifo_pkg::ADDR_W:0]    rd_gray_i,
   output logic [afifo_pkg::W_ADDR_W:0]  wr_gray_o,
   output logic                          w_full_o,
   output logic                          w_empty_o,
   output logic [afifo_pkg::ADDR_W:0]    w_level_o,
   afifo_mem_if.wr_src                   mem
);
   import afifo_pkg::*;

   logic [1:0]        rst_sync_q;
   logic              rst_w;
   logic              w_accept;
   logic [W_ADDR_W:0] wr_bin;
   logic [ADDR_W:0]   wr_bin_n;
   logic [ADDR_W:0]   rd_bin;
   logic [ADDR_W:0]   w_level;

   // reset enters at once and leaves two w_clk_i edges later
   always_ff @(posedge w_clk_i) begin
      if (rst_i) begin
         rst_sync_q <= 2'b11;
      end else begin
         rst_sync_q <= {rst_sync_q[0], 1'b0};
      end
   end

   assign rst_w = rst_sync_q[1];

   // writes while full are dropped here
   assign w_accept = w_en_i & ~w_full_o;

   afifo_gray_pointer #(
      .PTR_W(W_ADDR_W + 1)
   ) i_wr_ptr (
      .clk_i (w_clk_i),
      .rst_i (rst_w),
      .inc_i (w_accept),
      .bin_o (wr_bin),
      .gray_o(wr_gray_o)
   );

   // word pointer scaled to bytes
   assign wr_bin_n = {wr_bin, {RATIO_W{1'b0}}};
   assign rd_bin   = gray_to_bin(rd_gray_i);

   assign w_level   = wr_bin_n - rd_bin;
   assign w_level_o = w_level;

   // a whole word must fit or be present
   assign w_full_o  = w_level > (FIFO_SIZE - RATIO);
   assign w_empty_o = w_level < RATIO;

   assign mem.w_en   = w_accept;
   assign mem.w_addr = wr_bin[W_ADDR_W-1:0];

endmodule

/* source/afifo_ptr_sync.sv */
`timescale 1ns/1ps

module afifo_ptr_sync #(
   parameter int PTR_W = 4
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic [PTR_W-1:0] gray_i,
   output logic [PTR_W-1:0] gray_o
);

   logic [PTR_W-1:0] meta_q;
   logic [PTR_W-1:0] sync_q;

   // first stage may go metastable, second one is safe to use
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= gray_i;
         sync_q <= meta_q;
      end
   end

   assign gray_o = sync_q;

endmodule

/* source/afifo_gray_pointer.sv */
`timescale 1ns/1ps

module afifo_gray_pointer #(
   parameter int PTR_W = 4
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic             inc_i,
   output logic [PTR_W-1:0] bin_o,
   output logic [PTR_W-1:0] gray_o
);

   logic [PTR_W-1:0] bin_q;
   logic [PTR_W-1:0] bin_next;
   logic [PTR_W-1:0] gray_q;

   // the extra top bit wraps once per pass and tells full from empty
   assign bin_next = bin_q + 1'b1;

   // gray copy is registered so only one bit toggles at the crossing
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bin_q  <= '0;
         gray_q <= '0;
      end else if (inc_i) begin
         bin_q  <= bin_next;
         gray_q <= bin_next ^ (bin_next >> 1);
      end
   end

   assign bin_o  = bin_q;
   assign gray_o = gray_q;

endmodule

/* common/afifo_mem_if.sv */
`timescale 1ns/1ps

interface afifo_mem_if;
   import afifo_pkg::*;

   // write port, w_clk_i domain
   logic                w_en;
   logic [W_ADDR_W-1:0] w_addr;
   logic [W_DATA_W-1:0] w_data;

   // read port, r_clk_i domain
   logic                r_en;
   logic [W_ADDR_W-1:0] r_addr;
   logic [W_DATA_W-1:0] r_data;

   // write control owns the write request, data comes from the top
   modport wr_src (
      output w_en,
      output w_addr
   );

   modport rd_src (
      output r_en,
      output r_addr,
      input  r_data
   );

   modport ram (
      input  w_en, w_addr, w_data,
      input  r_en, r_addr,
      output r_data
   );

endinterface

/* common/afifo_pkg.sv */
package afifo_pkg;

   // write port carries words, read port returns bytes
   localparam int W_DATA_W = 16;
   localparam int R_DATA_W = 8;

   // depth counted in bytes on the narrow side
   localparam int ADDR_W = 4;

   // bytes per word, sized like a level so flag compares keep one width
   localparam logic [ADDR_W:0] RATIO = (ADDR_W + 1)'(W_DATA_W / R_DATA_W);
   localparam int RATIO_W = $clog2(W_DATA_W / R_DATA_W);

   // word address into the RAM
   localparam int W_ADDR_W = ADDR_W - RATIO_W;

   localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W + 1)'(1 << ADDR_W);

   // one stored word, seen whole by the RAM and by lane on the read side
   typedef union packed {
      logic [W_DATA_W-1:0]                   raw;
      logic [RATIO-1:0][R_DATA_W-1:0]        lanes;
   } mem_word_u;

   // gray to binary over the widest pointer
   // narrower pointers are zero extended, which leaves the result unchanged
   function automatic logic [ADDR_W:0] gray_to_bin(input logic [ADDR_W:0] gray);
      logic [ADDR_W:0] bin;
      bin[ADDR_W] = gray[ADDR_W];
      for (int i = ADDR_W - 1; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage
